//--- design/cpc_pkg.sv
// Shared types and constants for the CPC expansion core; page numbers assume 16 KB pages in a 23-bit space
package cpc_pkg;

	////////////////////
	// Basic types
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] cpu_addr_t; // Z80 address
	typedef logic [22:0] mem_addr_t; // Bit 22 selects expansion space
	typedef logic [8:0]  page_t;     // Top bit marks an expansion page
	typedef logic        bank_t;
	typedef logic [12:0] mf2_addr_t; // 8 KB shadow RAM

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_t;

	////////////////////
	// Memory pages
	localparam page_t MF2_PAGE    = 9'h1FF; // Multiface ROM
	localparam page_t UNUSED_PAGE = 9'h1EE; // Target of a malformed extension

	// OS, BASIC, AMSDOS and Multiface chunks, repeated for bank 1
	localparam page_t SYS_PAGE_TABLE [4] = '{9'h000, 9'h100, 9'h107, 9'h1FF};

	////////////////////
	// Multiface vectors and control port
	localparam cpu_addr_t NMI_VECTOR    = 16'h0066;
	localparam cpu_addr_t HIDE_VECTOR   = 16'h0065;
	localparam cpu_addr_t MF2_PORT_BASE = 16'hFEE8; // Bits 1..0 ignored

	// Upper address byte of the hardware ports that get shadowed
	localparam byte_t PORT_GA        = 8'h7F; // Gate array
	localparam byte_t PORT_CRTC_SEL  = 8'hBC;
	localparam byte_t PORT_CRTC_DATA = 8'hBD;
	localparam byte_t PORT_PPI       = 8'hF7; // 8255
	localparam byte_t PORT_ROM_SEL   = 8'hDF; // Upper ROM select

	////////////////////
	// Shadow RAM locations of stored registers
	localparam mf2_addr_t STORE_PEN_INDEX   = 13'h1FCF;
	localparam mf2_addr_t STORE_BORDER      = 13'h1FDF;
	localparam mf2_addr_t STORE_PEN_BASE    = 13'h1F90; // Plus pen number
	localparam mf2_addr_t STORE_SCREEN_MODE = 13'h1FEF;
	localparam mf2_addr_t STORE_BANKING     = 13'h1FFF;
	localparam mf2_addr_t STORE_CRTC_SEL    = 13'h1CFF;
	localparam mf2_addr_t STORE_CRTC_BASE   = 13'h1DB0; // Plus CRTC register
	localparam mf2_addr_t STORE_PPI         = 13'h17FF;
	localparam mf2_addr_t STORE_UPPER_ROM   = 13'h1AAC;

endpackage

//--- design/cpu_bus_if.sv
// CPU side strobes as seen by the Multiface blocks; all signals are driven by the top level
interface cpu_bus_if import cpc_pkg::*; ();

	cpu_addr_t cpu_addr;
	byte_t     io_data;  // Data of an io write
	logic      io_wr;    // Level, edges detected by the users
	logic      m1;       // Opcode fetch
	logic      mem_wr;
	byte_t     mem_data; // Data of a memory write

	// NMI and paging logic only looks at io writes and fetches
	modport control (
		input cpu_addr,
		input io_data,
		input io_wr,
		input m1
	);

	// Shadow RAM sees the whole bus
	modport store (
		input cpu_addr,
		input io_data,
		input io_wr,
		input m1,
		input mem_wr,
		input mem_data
	);

endinterface

//--- design/rom_page_decoder.sv
// Expansion page from a two-letter extension; only upper case hex digits are recognised
module rom_page_decoder import cpc_pkg::*; (
	input  byte_t [1:0] file_ext, // [1] is the first character
	output page_t       start_page,
	output logic        combo
);

	logic [4:0] hi_digit;
	logic [4:0] lo_digit;

	// Valid flag and nibble of one extension character
	function automatic logic [4:0] hex_digit(input byte_t c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		if (c >= "A" && c <= "F")
			return {1'b1, c[3:0] + 4'd9};
		return 5'b0;
	endfunction

	assign hi_digit = hex_digit(file_ext[1]);
	assign lo_digit = hex_digit(file_ext[0]);

	always_comb begin
		start_page = UNUSED_PAGE; // Bad characters keep the unused nibbles
		combo = 1'b0;
		if (hi_digit[4])
			start_page[7:4] = hi_digit[3:0];
		if (lo_digit[4])
			start_page[3:0] = lo_digit[3:0];

		// Special files going to main memory
		if (file_ext == "ZZ")
			start_page = '0;
		if (file_ext == "Z0") begin
			start_page = '0;
			combo = 1'b1; // Multiface ROM follows the first block
		end
	end

endmodule

//--- design/rom_loader.sv
// Download to memory writes; REF_DIV must be 2 or more and the host waits for ioctl_wait to fall
module rom_loader import cpc_pkg::*; #(
	parameter int REF_DIV = 16
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  byte_t       ioctl_index,    // 0 for system ROMs
	input  logic [15:0] ioctl_file_ext,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  byte_t       ioctl_data,
	output logic        ioctl_wait,
	output logic        boot_wr,
	output mem_addr_t   boot_addr,
	output bank_t       boot_bank,
	output byte_t       boot_data,
	output logic        page_commit,
	output page_t       commit_page
);

	localparam int CNT_W = (REF_DIV > 1) ? $clog2(REF_DIV) : 1;

	logic [CNT_W-1:0] ref_cnt;
	logic             ref_stb;
	logic             old_download;
	page_t            dec_page;
	logic             dec_combo;
	page_t            page;       // Base page of the current download
	logic             combo;
	logic             page_fixed; // Set once a combo file moved on to the Multiface ROM
	logic             exp_byte;   // Current byte goes to both banks
	logic [10:0]      sys_chunk;
	logic             sys_ok;

	rom_page_decoder u_decoder (
		.file_ext  (ioctl_file_ext),
		.start_page(dec_page),
		.combo     (dec_combo)
	);

	assign ref_stb   = (ref_cnt == '0);
	assign sys_chunk = ioctl_addr[24:14];
	assign sys_ok    = (sys_chunk < 11'd8); // Only 8 system chunks exist

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ref_cnt <= '0;
			old_download <= 1'b0;
			combo <= 1'b0;
			page_fixed <= 1'b0;
			exp_byte <= 1'b0;
			ioctl_wait <= 1'b0;
			boot_wr <= 1'b0;
			page_commit <= 1'b0;
		end else begin
			ref_cnt <= (ref_cnt == CNT_W'(REF_DIV - 1)) ? '0 : ref_cnt + 1'b1;
			old_download <= ioctl_download;
			boot_wr <= 1'b0;
			page_commit <= 1'b0;

			if (ioctl_download && !old_download) begin // Start of a new file
				page <= dec_page;
				combo <= (ioctl_index != 8'd0) && dec_combo;
				page_fixed <= 1'b0;
			end

			////////////////////
			// Byte accepted from the host
			if (ioctl_download && ioctl_wr) begin
				boot_data <= ioctl_data;
				boot_addr[13:0] <= ioctl_addr[13:0];
				exp_byte <= (ioctl_index != 8'd0);
				if (ioctl_index != 8'd0) begin
					ioctl_wait <= 1'b1;
					boot_bank <= 1'b0;
					if (page_fixed)
						boot_addr[22:14] <= page;
					else
						boot_addr[22:14] <= {page[8], page[7:0] + ioctl_addr[21:14]};
				end else if (sys_ok) begin
					ioctl_wait <= 1'b1;
					boot_addr[22:14] <= SYS_PAGE_TABLE[sys_chunk[1:0]];
					boot_bank <= sys_chunk[2]; // Chunks 4..7 are bank 1
				end
			end

			////////////////////
			// Strobe paced writes
			if (boot_wr) begin
				if (exp_byte && !boot_bank) begin
					boot_bank <= 1'b1; // Second copy on the next strobe
				end else begin
					ioctl_wait <= 1'b0;
					page_commit <= 1'b1;
					commit_page <= boot_addr[22:14];
					if (combo && &boot_addr[13:0]) begin
						combo <= 1'b0;
						page <= MF2_PAGE;
						page_fixed <= 1'b1;
					end
				end
			end else if (ref_stb && ioctl_wait) begin
				boot_wr <= 1'b1;
			end
		end
	end

	// A write is only issued for a byte the host is still waiting on
	assert property (@(posedge clk_sys) disable iff (reset) boot_wr |-> ioctl_wait);

endmodule

//--- design/rom_presence_map.sv
// Loaded expansion pages; a page counts as loaded after its first committed byte
module rom_presence_map import cpc_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      page_commit,
	input  page_t     commit_page,
	input  mem_addr_t mem_addr,
	output byte_t     rom_mask
);

	logic [255:0] loaded;

	always_ff @(posedge clk_sys) begin
		if (reset)
			loaded <= '0;
		else if (page_commit && commit_page[8]) // System pages are ignored
			loaded[commit_page[7:0]] <= 1'b1;
	end

	// Empty expansion pages read as FF
	assign rom_mask = (mem_addr[22] && !loaded[mem_addr[21:14]]) ? 8'hFF : 8'h00;

endmodule

//--- design/mf2_control.sv
// Multiface NMI and paging; the CPU is assumed to fetch the NMI vector while nmi is pending
module mf2_control import cpc_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  mf2_mode_t mode,
	input  logic      key_nmi,
	cpu_bus_if.control bus,
	output logic      nmi,
	output logic      mf2_active,
	output logic      mf2_rom_sel,
	output logic      mf2_ram_sel
);

	logic old_key_nmi;
	logic old_m1;
	logic old_io_wr;
	logic hidden;
	logic key_rise;
	logic m1_rise;
	logic port_wr;

	assign key_rise = key_nmi & ~old_key_nmi;
	assign m1_rise  = bus.m1 & ~old_m1;
	assign port_wr  = bus.io_wr & ~old_io_wr & (bus.cpu_addr[15:2] == MF2_PORT_BASE[15:2]);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key_nmi <= 1'b0;
			old_m1 <= 1'b0;
			old_io_wr <= 1'b0;
			nmi <= 1'b0;
			mf2_active <= 1'b0;
			hidden <= (mode != MF2_ENABLED);
		end else begin
			old_key_nmi <= key_nmi;
			old_m1 <= bus.m1;
			old_io_wr <= bus.io_wr;

			if (key_rise && !mf2_active && mode != MF2_DISABLED)
				nmi <= 1'b1;

			if (nmi && m1_rise && bus.cpu_addr == NMI_VECTOR) begin // NMI taken
				nmi <= 1'b0;
				mf2_active <= 1'b1;
				hidden <= 1'b0;
			end

			if (mf2_active && m1_rise && bus.cpu_addr == HIDE_VECTOR)
				hidden <= 1'b1;

			// FEE8 pages in unless hidden, FEEA pages out
			if (port_wr) begin
				mf2_active <= ~bus.cpu_addr[1] & ~hidden;
				if (!bus.cpu_addr[1] && !hidden)
					nmi <= 1'b0; // Paging in absorbs a pending request
			end
		end
	end

	assign mf2_rom_sel = mf2_active && (bus.cpu_addr[15:13] == 3'b000);
	assign mf2_ram_sel = mf2_active && (bus.cpu_addr[15:13] == 3'b001);

	assert property (@(posedge clk_sys) disable iff (reset) !(nmi && mf2_active));

endmodule

//--- design/mf2_shadow_ram.sv
// Multiface 8 KB RAM with register shadowing; read data lags the address by two cycles
module mf2_shadow_ram import cpc_pkg::*; (
	input  logic   clk_sys,
	cpu_bus_if.store bus,
	input  logic   mf2_ram_sel,
	input  byte_t  ext_data,
	output byte_t  cpu_rd_data
);

	byte_t     ram [2**$bits(mf2_addr_t)];
	logic      old_io_wr;
	logic      io_wr_rise;
	logic      do_store;
	logic      cpu_write;
	logic [4:0] pen_index;  // Last gate array pen select
	logic [3:0] crtc_reg;   // Last CRTC register select
	mf2_addr_t store_addr;
	mf2_addr_t ram_addr;
	byte_t     wr_data;
	logic      ram_we;
	byte_t     ram_q;

	////////////////////
	// Which hardware write lands where
	always_comb begin
		case (bus.cpu_addr[15:8])
			PORT_GA: begin
				case (bus.io_data[7:6]) // Gate array function bits
					2'b00: store_addr = STORE_PEN_INDEX;
					2'b01: store_addr = pen_index[4] ? STORE_BORDER :
						{STORE_PEN_BASE[12:4], pen_index[3:0]};
					2'b10: store_addr = STORE_SCREEN_MODE;
					default: store_addr = STORE_BANKING;
				endcase
			end
			PORT_CRTC_SEL:  store_addr = STORE_CRTC_SEL;
			PORT_CRTC_DATA: store_addr = {STORE_CRTC_BASE[12:4], crtc_reg};
			PORT_PPI:       store_addr = STORE_PPI;
			PORT_ROM_SEL:   store_addr = STORE_UPPER_ROM;
			default:        store_addr = '0; // Not shadowed
		endcase
	end

	assign io_wr_rise = bus.io_wr & ~old_io_wr;
	assign do_store   = io_wr_rise & (|store_addr);
	assign cpu_write  = mf2_ram_sel & bus.mem_wr & ~do_store; // Stores win

	always_ff @(posedge clk_sys) begin
		old_io_wr <= bus.io_wr;
		if (do_store) begin
			if (bus.cpu_addr[15:8] == PORT_GA && bus.io_data[7:6] == 2'b00)
				pen_index <= bus.io_data[4:0];
			if (bus.cpu_addr[15:8] == PORT_CRTC_SEL)
				crtc_reg <= bus.io_data[3:0];
			ram_addr <= store_addr;
			wr_data <= bus.io_data;
			ram_we <= 1'b1;
		end else if (cpu_write) begin
			ram_addr <= bus.cpu_addr[12:0];
			wr_data <= bus.mem_data;
			ram_we <= 1'b1;
		end else begin
			ram_addr <= bus.cpu_addr[12:0]; // Plain read
			ram_we <= 1'b0;
		end
	end

	////////////////////
	// RAM array, read before write
	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram[ram_addr] <= wr_data;
		ram_q <= ram[ram_addr];
	end

	assign cpu_rd_data = mf2_ram_sel ? ram_q : ext_data;

	// The CPU never writes the paged-in RAM during a shadowed io write
	assert property (@(posedge clk_sys) do_store |-> !(mf2_ram_sel && bus.mem_wr));

endmodule

//--- design/cpc_expansion_top.sv
// ROM download and Multiface expansion of the CPC core; SDRAM, CPU and video live outside this block
module cpc_expansion_top import cpc_pkg::*; #(
	parameter int REF_DIV = 16 // clk_sys cycles per memory write slot
) (
	input  logic        clk_sys,
	input  logic        reset,

	// Download port
	input  logic        ioctl_download,
	input  byte_t       ioctl_index,
	input  logic [15:0] ioctl_file_ext,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  byte_t       ioctl_data,
	output logic        ioctl_wait,
	output logic        boot_wr,
	output mem_addr_t   boot_addr,
	output bank_t       boot_bank,
	output byte_t       boot_data,

	// CPU side
	input  mem_addr_t   mem_addr,
	input  byte_t       sdram_data,
	input  mf2_mode_t   mode,
	input  logic        key_nmi,
	input  cpu_addr_t   cpu_addr,
	input  byte_t       io_data,
	input  logic        io_wr,
	input  logic        m1,
	input  logic        mem_wr,
	input  byte_t       mem_data,
	output logic        nmi,
	output logic        mf2_active,
	output logic        mf2_rom_sel,
	output byte_t       cpu_rd_data
);

	logic  page_commit;
	page_t commit_page;
	byte_t rom_mask;
	logic  mf2_ram_sel;

	cpu_bus_if bus ();

	assign bus.cpu_addr = cpu_addr;
	assign bus.io_data  = io_data;
	assign bus.io_wr    = io_wr;
	assign bus.m1       = m1;
	assign bus.mem_wr   = mem_wr;
	assign bus.mem_data = mem_data;

	rom_loader #(.REF_DIV(REF_DIV)) u_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.ioctl_file_ext(ioctl_file_ext),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.ioctl_wait    (ioctl_wait),
		.boot_wr       (boot_wr),
		.boot_addr     (boot_addr),
		.boot_bank     (boot_bank),
		.boot_data     (boot_data),
		.page_commit   (page_commit),
		.commit_page   (commit_page)
	);

	rom_presence_map u_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.page_commit(page_commit),
		.commit_page(commit_page),
		.mem_addr   (mem_addr),
		.rom_mask   (rom_mask)
	);

	mf2_control u_mf2_ctrl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (mode),
		.key_nmi    (key_nmi),
		.bus        (bus.control),
		.nmi        (nmi),
		.mf2_active (mf2_active),
		.mf2_rom_sel(mf2_rom_sel),
		.mf2_ram_sel(mf2_ram_sel)
	);

	mf2_shadow_ram u_mf2_ram (
		.clk_sys    (clk_sys),
		.bus        (bus.store),
		.mf2_ram_sel(mf2_ram_sel),
		.ext_data   (sdram_data | rom_mask), // Unloaded pages float high
		.cpu_rd_data(cpu_rd_data)
	);

endmodule

//--- testbench/tb_util.svh
// Helpers included inside the testbench module; they use its signals and model state directly
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

	////////////////////
	// Random numbers

	// 16-bit Fibonacci LFSR with taps 16 14 13 11, one step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		logic        fb;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	////////////////////
	// Error reporting and compares
	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic compare_bank(input string name, input bank_t exp, input bank_t act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	// Host side wait for the end of a mapped byte
	task automatic wait_ioctl_idle();
		int n;
		n = 0;
		while (ioctl_wait) begin
			if (n == WAIT_LIMIT)
				stop_on_error("Timed out waiting for ioctl_wait to fall");
			@(negedge clk_sys);
			n++;
		end
	endtask

	////////////////////
	// Reference model
	function automatic page_t ref_sys_page(input logic [1:0] chunk);
		case (chunk)
			2'd0: return 9'h000;    // OS
			2'd1: return 9'h100;    // BASIC
			2'd2: return 9'h107;    // AMSDOS
			default: return 9'h1FF; // Multiface ROM
		endcase
	endfunction

	// Two hex characters give the low byte of an expansion page
	function automatic page_t ref_ext_page(input logic [15:0] ext);
		page_t p;
		byte_t c;
		p = UNUSED_PAGE;
		if (ext == "ZZ" || ext == "Z0")
			return 9'h000;
		for (int k = 0; k < 2; k++) begin
			c = ext[8*k +: 8];
			if (c inside {["0":"9"]})
				p[4*k +: 4] = 4'(c - 8'h30);
			else if (c inside {["A":"F"]})
				p[4*k +: 4] = 4'(c - 8'h37);
		end
		return p;
	endfunction

	function automatic mem_addr_t ref_boot_addr(input byte_t index, input logic [24:0] addr,
			input page_t base, input logic fixed);
		page_t p;
		if (index == 8'd0)
			p = ref_sys_page(addr[15:14]);
		else if (fixed)
			p = base; // Combo file after its first block
		else
			p = {base[8], base[7:0] + addr[21:14]};
		return {p, addr[13:0]};
	endfunction

	function automatic byte_t ref_mask(input mem_addr_t a);
		return (a[22] && !model_loaded[a[21:14]]) ? 8'hFF : 8'h00;
	endfunction

	function automatic mf2_addr_t ref_shadow_addr(input byte_t port, input byte_t data,
			input logic [4:0] pen, input logic [3:0] crtc);
		case (port)
			PORT_GA: begin
				case (data[7:6])
					2'b00: return STORE_PEN_INDEX;
					2'b01: return pen[4] ? STORE_BORDER : STORE_PEN_BASE + mf2_addr_t'(pen[3:0]);
					2'b10: return STORE_SCREEN_MODE;
					default: return STORE_BANKING;
				endcase
			end
			PORT_CRTC_SEL:  return STORE_CRTC_SEL;
			PORT_CRTC_DATA: return STORE_CRTC_BASE + mf2_addr_t'(crtc);
			PORT_PPI:       return STORE_PPI;
			PORT_ROM_SEL:   return STORE_UPPER_ROM;
			default:        return '0; // Port not shadowed
		endcase
	endfunction

`endif

//--- testbench/cpc_expansion_tb.sv
// Self-checking testbench at REF_DIV 16; shadow RAM is only read back where it was written
module cpc_expansion_tb import cpc_pkg::*; ();

	localparam int REF_DIV    = 16;
	localparam int WAIT_LIMIT = 4 * REF_DIV + 8;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	byte_t       ioctl_index;
	logic [15:0] ioctl_file_ext;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	byte_t       ioctl_data;
	logic        ioctl_wait;
	logic        boot_wr;
	mem_addr_t   boot_addr;
	bank_t       boot_bank;
	byte_t       boot_data;
	mem_addr_t   mem_addr;
	byte_t       sdram_data;
	mf2_mode_t   mode;
	logic        key_nmi;
	cpu_addr_t   cpu_addr;
	byte_t       io_data;
	logic        io_wr;
	logic        m1;
	logic        mem_wr;
	byte_t       mem_data;
	logic        nmi;
	logic        mf2_active;
	logic        mf2_rom_sel;
	byte_t       cpu_rd_data;

	// Model state
	logic [15:0]  lfsr_state;
	logic [31:0]  expect_q [$]; // {bank, addr, data}
	logic [31:0]  exp_w;
	page_t        model_page;
	logic         model_combo;
	logic         model_fixed;
	logic [255:0] model_loaded;
	byte_t        shadow_model [8192];
	logic [4:0]   model_pen;
	logic [3:0]   model_crtc;
	cpu_addr_t    written [12];

	`include "tb_util.svh"

	cpc_expansion_top #(.REF_DIV(REF_DIV)) DUT (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_data(ioctl_data), .ioctl_wait(ioctl_wait), .boot_wr(boot_wr),
		.boot_addr(boot_addr), .boot_bank(boot_bank), .boot_data(boot_data),
		.mem_addr(mem_addr), .sdram_data(sdram_data), .mode(mode), .key_nmi(key_nmi),
		.cpu_addr(cpu_addr), .io_data(io_data), .io_wr(io_wr), .m1(m1), .mem_wr(mem_wr),
		.mem_data(mem_data), .nmi(nmi), .mf2_active(mf2_active),
		.mf2_rom_sel(mf2_rom_sel), .cpu_rd_data(cpu_rd_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Each boot write must match the oldest expected one
	always @(negedge clk_sys) begin
		if (boot_wr) begin
			if (expect_q.size() == 0) begin
				stop_on_error("boot_wr pulsed while no memory write was expected");
			end else begin
				exp_w = expect_q.pop_front();
				compare_addr("boot_addr", exp_w[30:8], boot_addr);
				compare_bank("boot_bank", exp_w[31], boot_bank);
				compare_byte("boot_data", exp_w[7:0], boot_data);
			end
		end
	end

	////////////////////
	// Download stimulus
	task automatic start_download(input byte_t index, input logic [15:0] ext);
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		ioctl_download = 1'b1; // Page latched on this edge
		ioctl_index = index;
		ioctl_file_ext = ext;
		model_page = ref_ext_page(ext);
		model_combo = (index != 8'd0) && (ext == "Z0");
		model_fixed = 1'b0;
	endtask

	task automatic send_byte(input logic [24:0] addr, input byte_t data);
		mem_addr_t exp_a;
		logic      mapped;
		mapped = (ioctl_index != 8'd0) || (addr[24:14] < 11'd8);
		exp_a = ref_boot_addr(ioctl_index, addr, model_page, model_fixed);
		if (mapped) begin
			if (ioctl_index == 8'd0) begin
				expect_q.push_back({addr[16], exp_a, data}); // Chunks 4..7 in bank 1
			end else begin
				expect_q.push_back({1'b0, exp_a, data});
				expect_q.push_back({1'b1, exp_a, data});
			end
			if (exp_a[22])
				model_loaded[exp_a[21:14]] = 1'b1;
			if (model_combo && &addr[13:0]) begin
				model_combo = 1'b0;
				model_fixed = 1'b1;
				model_page = MF2_PAGE;
			end
		end
		@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		compare_bit("ioctl_wait after byte", mapped, ioctl_wait);
		if (mapped) begin
			wait_ioctl_idle();
			if (expect_q.size() != 0)
				stop_on_error("ioctl_wait fell before all boot writes were seen");
		end else begin
			repeat (WAIT_LIMIT) begin // Refused byte stays silent
				@(negedge clk_sys);
				compare_bit("ioctl_wait refused byte", 1'b0, ioctl_wait);
			end
		end
	endtask

	////////////////////
	// CPU stimulus
	task automatic io_write(input cpu_addr_t addr, input byte_t data);
		mf2_addr_t sa;
		sa = ref_shadow_addr(addr[15:8], data, model_pen, model_crtc);
		if (sa != '0)
			shadow_model[sa] = data;
		if (addr[15:8] == PORT_GA && data[7:6] == 2'b00)
			model_pen = data[4:0];
		if (addr[15:8] == PORT_CRTC_SEL)
			model_crtc = data[3:0];
		@(negedge clk_sys);
		cpu_addr = addr;
		io_data = data;
		io_wr = 1'b1;
		@(negedge clk_sys);
		io_wr = 1'b0;
	endtask

	task automatic mem_write(input cpu_addr_t addr, input byte_t data);
		shadow_model[addr[12:0]] = data;
		@(negedge clk_sys);
		cpu_addr = addr;
		mem_data = data;
		mem_wr = 1'b1;
		@(negedge clk_sys);
		mem_wr = 1'b0;
	endtask

	task automatic check_shadow(input string name, input mf2_addr_t sa);
		@(negedge clk_sys);
		cpu_addr = {3'b001, sa}; // RAM window 2000-3FFF
		repeat (2) @(negedge clk_sys);
		compare_byte(name, shadow_model[sa], cpu_rd_data);
	endtask

	task automatic check_ext(input string name, input mem_addr_t addr, input byte_t sdram);
		@(negedge clk_sys);
		cpu_addr = 16'hC000; // Outside the Multiface windows
		mem_addr = addr;
		sdram_data = sdram;
		@(negedge clk_sys);
		compare_byte(name, sdram | ref_mask(addr), cpu_rd_data);
	endtask

	task automatic fetch(input cpu_addr_t addr);
		@(negedge clk_sys);
		cpu_addr = addr;
		m1 = 1'b1;
		@(negedge clk_sys);
		m1 = 1'b0;
	endtask

	task automatic key_press(input logic expect_nmi);
		@(negedge clk_sys);
		key_nmi = 1'b1;
		@(negedge clk_sys);
		compare_bit("nmi after key", expect_nmi, nmi);
		key_nmi = 1'b0;
	endtask

	task automatic check_rom_sel(input cpu_addr_t addr, input logic expect_sel);
		@(negedge clk_sys);
		cpu_addr = addr;
		@(negedge clk_sys);
		compare_bit("mf2_rom_sel", expect_sel, mf2_rom_sel);
	endtask

	initial begin
		int i;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_file_ext = 16'h0000;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = 8'd0;
		mem_addr = '0;
		sdram_data = 8'd0;
		mode = MF2_ENABLED;
		key_nmi = 1'b0;
		cpu_addr = 16'h0000;
		io_data = 8'd0;
		io_wr = 1'b0;
		m1 = 1'b0;
		mem_wr = 1'b0;
		mem_data = 8'd0;
		lfsr_state = 16'd7;
		model_loaded = '0;
		model_pen = 5'd0;
		model_crtc = 4'd0;
		repeat (2) @(posedge clk_sys); // Two clock cycles in reset
		@(negedge clk_sys);
		reset = 1'b0;

		// System ROMs, one byte per chunk, then a chunk that does not exist
		start_download(8'd0, 16'h0000);
		for (i = 0; i < 8; i++)
			send_byte({11'(i), 14'(rand_bits(14))}, 8'(rand_bits(8)));
		send_byte({11'd8, 14'(rand_bits(14))}, 8'(rand_bits(8)));

		// Expansion ROM 1A, chunks 0 and 2
		start_download(8'd1, "1A");
		for (i = 0; i < 8; i++)
			send_byte({11'(i < 6 ? 0 : 2), 14'(rand_bits(14))}, 8'(rand_bits(8)));
		check_ext("mask page 11A", {9'h11A, 14'(rand_bits(14))}, 8'h00);
		check_ext("mask page 11B", {9'h11B, 14'(rand_bits(14))}, 8'h00);

		// Combo file moves to the Multiface ROM after its first block
		start_download(8'd2, "Z0");
		send_byte(25'h0003FFE, 8'(rand_bits(8)));
		send_byte(25'h0003FFF, 8'(rand_bits(8)));
		send_byte(25'h0004000, 8'(rand_bits(8)));
		send_byte(25'h0004001, 8'(rand_bits(8)));
		@(negedge clk_sys);
		ioctl_download = 1'b0;

		////////////////////
		// NMI and paging
		mode = MF2_DISABLED;
		key_press(1'b0);
		mode = MF2_ENABLED;
		key_press(1'b1);
		fetch(NMI_VECTOR);
		compare_bit("nmi after vector fetch", 1'b0, nmi);
		compare_bit("mf2_active after vector fetch", 1'b1, mf2_active);
		check_rom_sel(16'(rand_bits(13)), 1'b1);
		check_rom_sel(16'h2000 | 16'(rand_bits(13)), 1'b0);
		check_rom_sel(16'hC000, 1'b0);

		// Shadow RAM through CPU writes
		for (i = 0; i < 12; i++) begin
			written[i] = 16'h2000 | 16'(rand_bits(13));
			mem_write(written[i], 8'(rand_bits(8)));
		end
		for (i = 0; i < 12; i++)
			check_shadow("cpu write readback", written[i][12:0]);

		// Register stores
		io_write(16'h7F00, {4'b0000, 4'(rand_bits(4))}); // Pen select
		io_write(16'h7F00, {2'b01, 6'(rand_bits(6))});   // Pen colour
		check_shadow("pen index store", STORE_PEN_INDEX);
		check_shadow("pen colour store", ref_shadow_addr(PORT_GA, 8'h40, model_pen, model_crtc));
		io_write(16'hBC00, {4'h0, 4'(rand_bits(4))});
		io_write(16'hBD00, 8'(rand_bits(8)));
		check_shadow("crtc select store", STORE_CRTC_SEL);
		check_shadow("crtc value store",
			ref_shadow_addr(PORT_CRTC_DATA, 8'h00, model_pen, model_crtc));
		check_ext("system space read", {1'b0, 22'(rand_bits(14))}, 8'(rand_bits(8)));
		check_ext("loaded page read", {9'h11A, 14'(rand_bits(14))}, 8'(rand_bits(8)));
		check_ext("empty page read", {9'h11B, 14'(rand_bits(14))}, 8'(rand_bits(8)));

		////////////////////
		// Control port and hide
		io_write(16'hFEEA, 8'(rand_bits(8)));
		compare_bit("mf2_active after FEEA", 1'b0, mf2_active);
		io_write(16'hFEE8, 8'(rand_bits(8)));
		compare_bit("mf2_active after FEE8", 1'b1, mf2_active);
		fetch(HIDE_VECTOR);
		io_write(16'hFEEA, 8'(rand_bits(8)));
		io_write(16'hFEE8, 8'(rand_bits(8)));
		compare_bit("mf2_active while hidden", 1'b0, mf2_active);

		if (expect_q.size() != 0) begin
			stop_on_error("Boot writes were still expected at the end of the test");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

//--- sim.f
+incdir+testbench
design/cpc_pkg.sv
design/cpu_bus_if.sv
design/rom_page_decoder.sv
design/rom_loader.sv
design/rom_presence_map.sv
design/mf2_control.sv
design/mf2_shadow_ram.sv
design/cpc_expansion_top.sv
testbench/cpc_expansion_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := cpc_expansion_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
